// ==== hw/dp_defs.svh ====
`ifndef DP_DEFS_SVH
`define DP_DEFS_SVH

// ************************************************************
// Datapath sizing
// ************************************************************

// Width of a register and of every operand.
`define DP_XLEN 32

// Number of general purpose registers.
`define DP_NREGS 32

// Register address width.
`define DP_RAW 5

// Return address offset written by JAL.
`define DP_LINK_OFS 8

`endif

// ==== hw/dp_pkg.sv ====
`include "dp_defs.svh"

package dp_pkg;

	typedef enum logic [3:0] {
		NOP, ADD, SUB, AND, OR, ADDI, ORI, LUI, MUL, JAL
	} opE;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} aluOpE;
	typedef enum logic [1:0] {RES_ALU, RES_MUL, RES_LUI, RES_LINK} resSelE;
	typedef enum logic [1:0] {REG, FX, FM1, FM2} fwdSelE;	// Youngest stage wins.

	typedef struct packed {
		logic valid;
		opE op;
		logic [`DP_RAW-1:0] rs;
		logic [`DP_RAW-1:0] rt;
		logic [`DP_RAW-1:0] rd;
		logic [15:0] imm;
		logic [`DP_XLEN-1:0] pc;
	} issueT;

	typedef struct packed {
		aluOpE aluOp;
		logic useImm;	// Operand B is imm32.
		logic zeroExt;	// ORI style immediate.
		resSelE resSel;
		logic writeEn;
		logic [`DP_RAW-1:0] dest;
	} ctrlT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [`DP_RAW-1:0] rs;
		logic [`DP_RAW-1:0] rt;
		logic [`DP_XLEN-1:0] imm32;
		logic [`DP_XLEN-1:0] pc;
	} decT;

	typedef struct packed {
		logic valid;
		logic writeEn;
		logic [`DP_RAW-1:0] dest;
		logic [`DP_XLEN-1:0] data;
	} resT;

	typedef struct packed {
		logic valid;
		logic [`DP_RAW-1:0] addr;
		logic [`DP_XLEN-1:0] data;
	} wbT;

endpackage

// ==== hw/instrDecode.sv ====
`timescale 1ns/1ps
`include "dp_defs.svh"

module instrDecode (
	input logic clk,
	input logic rst,
	input dp_pkg::issueT issue,
	output dp_pkg::decT dStage
);
	import dp_pkg::*;

	ctrlT ctrl;
	logic [`DP_XLEN-1:0] imm32;

	// ************************************************************
	// Control word from the opcode
	// ************************************************************
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = ALU_ADD;
		ctrl.resSel = RES_ALU;
		unique case (issue.op)
			ADD: begin ctrl.writeEn = 1'b1; ctrl.dest = issue.rd; end
			SUB: begin ctrl.aluOp = ALU_SUB; ctrl.writeEn = 1'b1; ctrl.dest = issue.rd; end
			AND: begin ctrl.aluOp = ALU_AND; ctrl.writeEn = 1'b1; ctrl.dest = issue.rd; end
			OR: begin ctrl.aluOp = ALU_OR; ctrl.writeEn = 1'b1; ctrl.dest = issue.rd; end
			ADDI: begin ctrl.useImm = 1'b1; ctrl.writeEn = 1'b1; ctrl.dest = issue.rt; end
			ORI: begin
				ctrl.aluOp = ALU_OR;
				ctrl.useImm = 1'b1;
				ctrl.zeroExt = 1'b1;
				ctrl.writeEn = 1'b1;
				ctrl.dest = issue.rt;
			end
			LUI: begin ctrl.resSel = RES_LUI; ctrl.writeEn = 1'b1; ctrl.dest = issue.rt; end
			MUL: begin ctrl.resSel = RES_MUL; ctrl.writeEn = 1'b1; ctrl.dest = issue.rd; end
			JAL: begin ctrl.resSel = RES_LINK; ctrl.writeEn = 1'b1; ctrl.dest = 5'd31; end
			default: ctrl.writeEn = 1'b0;	// NOP writes nothing.
		endcase
	end

	// Immediate extension.
	always_comb begin
		if (ctrl.zeroExt)
			imm32 = {{(`DP_XLEN-16){1'b0}}, issue.imm};
		else if (issue.op == LUI)
			imm32 = {issue.imm, {(`DP_XLEN-16){1'b0}}};	// Upper half.
		else
			imm32 = {{(`DP_XLEN-16){issue.imm[15]}}, issue.imm};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dStage <= '0;
		end else begin
			dStage.valid <= issue.valid;
			dStage.ctrl <= ctrl;
			dStage.rs <= issue.rs;
			dStage.rt <= issue.rt;
			dStage.imm32 <= imm32;
			dStage.pc <= issue.pc;
		end
	end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`include "dp_defs.svh"

module regFile (
	input logic clk,
	input logic rst,
	input logic [`DP_RAW-1:0] rdAddrA,
	input logic [`DP_RAW-1:0] rdAddrB,
	output logic [`DP_XLEN-1:0] rdDataA,
	output logic [`DP_XLEN-1:0] rdDataB,
	input dp_pkg::wbT wr
);

	logic [`DP_XLEN-1:0] regs [`DP_NREGS];

	// ************************************************************
	// Storage
	// ************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DP_NREGS; i++)
				regs[i] <= '0;
		end else if (wr.valid && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Register 0 is hardwired; a same-cycle write is seen by the reader.
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wr.valid && wr.addr == rdAddrA) ? wr.data :
		regs[rdAddrA];

	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wr.valid && wr.addr == rdAddrB) ? wr.data :
		regs[rdAddrB];

endmodule

// ==== hw/operandForward.sv ====
`timescale 1ns/1ps
`include "dp_defs.svh"

module operandForward (
	input dp_pkg::decT dStage,
	input logic [`DP_XLEN-1:0] regA,
	input logic [`DP_XLEN-1:0] regB,
	input dp_pkg::resT xRes,
	input dp_pkg::resT m1Res,
	input dp_pkg::resT m2Res,
	output logic [`DP_XLEN-1:0] opA,
	output logic [`DP_XLEN-1:0] opB
);
	import dp_pkg::*;

	fwdSelE selA;
	fwdSelE selB;
	logic [`DP_XLEN-1:0] rtVal;

	function automatic logic hit(input resT r, input logic [`DP_RAW-1:0] src);
		return r.valid && r.writeEn && (r.dest == src) && (src != '0);
	endfunction

	// Priority X, M1, M2, then the register file.
	function automatic fwdSelE pickSel(input logic [`DP_RAW-1:0] src,
			input resT x, input resT m1, input resT m2);
		if (hit(x, src))
			return FX;
		else if (hit(m1, src))
			return FM1;
		else if (hit(m2, src))
			return FM2;
		return REG;
	endfunction

	function automatic logic [`DP_XLEN-1:0] fwdMux(input fwdSelE sel,
			input logic [`DP_XLEN-1:0] regVal, input resT x, input resT m1, input resT m2);
		unique case (sel)
			FX: return x.data;
			FM1: return m1.data;
			FM2: return m2.data;
			default: return regVal;
		endcase
	endfunction

	// ************************************************************
	// Operand selection
	// ************************************************************
	always_comb begin
		selA = pickSel(dStage.rs, xRes, m1Res, m2Res);
		selB = pickSel(dStage.rt, xRes, m1Res, m2Res);
		opA = fwdMux(selA, regA, xRes, m1Res, m2Res);
		rtVal = fwdMux(selB, regB, xRes, m1Res, m2Res);
		opB = dStage.ctrl.useImm ? dStage.imm32 : rtVal;	// Immediate ops.
	end

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/1ps
`include "dp_defs.svh"

module execUnit (
	input dp_pkg::decT dStage,
	input logic [`DP_XLEN-1:0] opA,
	input logic [`DP_XLEN-1:0] opB,
	output dp_pkg::resT exRes
);
	import dp_pkg::*;

	logic [`DP_XLEN-1:0] aluRes;
	logic [`DP_XLEN-1:0] mulRes;
	logic [`DP_XLEN-1:0] linkAddr;

	// ************************************************************
	// ALU and multiplier
	// ************************************************************
	always_comb begin
		unique case (dStage.ctrl.aluOp)
			ALU_ADD: aluRes = opA + opB;
			ALU_SUB: aluRes = opA - opB;
			ALU_AND: aluRes = opA & opB;
			default: aluRes = opA | opB;
		endcase
	end

	assign mulRes = opA * opB;	// Low word only.

	assign linkAddr = dStage.pc + `DP_XLEN'(`DP_LINK_OFS);

	// ************************************************************
	// EX result selection
	// ************************************************************
	always_comb begin
		exRes.valid = dStage.valid;
		exRes.writeEn = dStage.ctrl.writeEn;
		exRes.dest = dStage.ctrl.dest;
		unique case (dStage.ctrl.resSel)
			RES_ALU: exRes.data = aluRes;
			RES_MUL: exRes.data = mulRes;
			RES_LUI: exRes.data = dStage.imm32;	// Already shifted in decode.
			default: exRes.data = linkAddr;
		endcase
	end

endmodule

// ==== hw/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst,
	input payloadT d,
	output payloadT q
);

	// Reset leaves the stage empty.
	always_ff @(posedge clk) begin
		if (rst)
			q <= '0;
		else
			q <= d;
	end

endmodule

// ==== hw/writebackSelect.sv ====
`timescale 1ns/1ps

module writebackSelect (
	input logic clk,
	input logic rst,
	input dp_pkg::resT wRes,
	output dp_pkg::wbT wb
);

	logic doWrite;

	// Only real writes to r1..r31 leave the pipeline.
	assign doWrite = wRes.valid && wRes.writeEn && (wRes.dest != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb <= '0;
		end else begin
			wb.valid <= doWrite;
			wb.addr <= wRes.dest;
			wb.data <= wRes.data;
		end
	end

endmodule

// ==== hw/dpCore.sv ====
`timescale 1ns/1ps
`include "dp_defs.svh"

module dpCore (
	input logic clk,
	input logic rst,
	input dp_pkg::issueT issue,
	output dp_pkg::wbT wb
);
	import dp_pkg::*;

	decT dStage;
	logic [`DP_XLEN-1:0] regA;
	logic [`DP_XLEN-1:0] regB;
	logic [`DP_XLEN-1:0] opA;
	logic [`DP_XLEN-1:0] opB;
	resT exRes;
	resT xRes;
	resT m1Res;
	resT m2Res;

	// ************************************************************
	// Decode and operands
	// ************************************************************
	instrDecode uDec (.clk(clk), .rst(rst), .issue(issue), .dStage(dStage));

	regFile uRf (
		.clk(clk),
		.rst(rst),
		.rdAddrA(dStage.rs),
		.rdAddrB(dStage.rt),
		.rdDataA(regA),
		.rdDataB(regB),
		.wr(wb)	// Written one edge after wb is shown.
	);

	operandForward uFwd (
		.dStage(dStage),
		.regA(regA),
		.regB(regB),
		.xRes(xRes),
		.m1Res(m1Res),
		.m2Res(m2Res),
		.opA(opA),
		.opB(opB)
	);

	execUnit uEx (.dStage(dStage), .opA(opA), .opB(opB), .exRes(exRes));

	// ************************************************************
	// Result pipeline
	// ************************************************************
	stageReg #(.payloadT(resT)) uX (.clk(clk), .rst(rst), .d(exRes), .q(xRes));
	stageReg #(.payloadT(resT)) uM1 (.clk(clk), .rst(rst), .d(xRes), .q(m1Res));
	stageReg #(.payloadT(resT)) uM2 (.clk(clk), .rst(rst), .d(m1Res), .q(m2Res));

	writebackSelect uWb (.clk(clk), .rst(rst), .wRes(m2Res), .wb(wb));	// W stage.

endmodule

// ==== tb/dpCore_assert.sv ====
`timescale 1ns/1ps

module dpCore_assert (
	input logic clk,
	input logic rst,
	input dp_pkg::issueT issue,
	input dp_pkg::wbT wb
);
	import dp_pkg::*;

	logic [4:0] issueDest;
	logic issueWrites;
	int failCount = 0;	// Read by the testbench.

	always_comb begin
		case (issue.op)
			ADD, SUB, AND, OR, MUL: issueDest = issue.rd;
			ADDI, ORI, LUI: issueDest = issue.rt;
			JAL: issueDest = 5'd31;
			default: issueDest = '0;
		endcase
	end

	assign issueWrites = issue.valid && issue.op != NOP && issueDest != '0;

	// ************************************************************
	// Writeback port
	// ************************************************************
	addrNonZero: assert property (@(posedge clk) disable iff (rst)
		wb.valid |-> wb.addr != '0)
	else begin
		$error("wb.valid with wb.addr zero");
		failCount++;
	end

	dataKnown: assert property (@(posedge clk) disable iff (rst)
		wb.valid |-> !$isunknown(wb.data))
	else begin
		$error("wb.data unknown while valid");
		failCount++;
	end

	// Captured at the issue edge, shown 4 edges later.
	issueToWb: assert property (@(posedge clk) disable iff (rst)
		issueWrites |=> ##4 wb.valid)
	else begin
		$error("Writing issue gave no wb.valid");
		failCount++;
	end

	wbFromIssue: assert property (@(posedge clk) disable iff (rst)
		wb.valid |-> $past(issueWrites, 5))
	else begin
		$error("wb.valid without a writing issue");
		failCount++;
	end

endmodule

bind dpCore dpCore_assert uAssert (.clk(clk), .rst(rst), .issue(issue), .wb(wb));

// ==== tb/dpCore_tb.sv ====
`timescale 1ns/1ps
`include "dp_defs.svh"

module dpCore_tb;
	import dp_pkg::*;

	logic clk;
	logic rst;
	issueT issue;
	wbT wb;

	logic [31:0] refRegs [32];
	wbT expQ [$];
	logic [31:0] expCyc [$];
	logic [31:0] cyc;
	integer seed = 82;
	int errCount;
	int testsRun;
	int testsFailed;

	dpCore u_dut (.clk(clk), .rst(rst), .issue(issue), .wb(wb));

	always #4 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// ************************************************************
	// Compare tasks and the writeback monitor
	// ************************************************************
	task automatic checkWb(input string name, input wbT got, input wbT exp);
		if (got !== exp) begin
			$display(
				"Mismatch %s: got valid=%h addr=%h data=%h, expected valid=%h addr=%h data=%h",
				name, got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data);
			errCount++;
		end
	endtask

	task automatic checkData(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			errCount++;
		end
	endtask

	function automatic int totalErrors();
		return errCount + u_dut.uAssert.failCount;
	endfunction

	// Every wb.valid must match the oldest expected write.
	always @(posedge clk) begin
		if (!rst && wb.valid) begin
			if (expQ.size() == 0) begin
				$display("Writeback to r%0d appeared with no write expected", wb.addr);
				errCount++;
			end else begin
				checkWb("wb", wb, expQ.pop_front());
				checkData("wb cycle", cyc, expCyc.pop_front());
			end
		end
	end

	// ************************************************************
	// Reference model
	// ************************************************************
	function automatic logic [4:0] destReg(input opE op, input logic [4:0] rt,
			input logic [4:0] rd);
		case (op)
			ADD, SUB, AND, OR, MUL: return rd;
			ADDI, ORI, LUI: return rt;
			JAL: return 5'd31;
			default: return 5'd0;
		endcase
	endfunction

	function automatic logic [31:0] expectedResult(input opE op, input logic [31:0] a,
			input logic [31:0] b, input logic [15:0] imm, input logic [31:0] pc);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			ADDI: return a + {{16{imm[15]}}, imm};
			ORI: return a | {16'h0000, imm};
			LUI: return {imm, 16'h0000};
			MUL: return a * b;	// Low word of the product.
			JAL: return pc + `DP_LINK_OFS;
			default: return 32'h0;
		endcase
	endfunction

	// Drives one instruction for one cycle and records its expected write.
	task automatic sendOp(input opE op, input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [15:0] imm, input logic [31:0] pc);
		issueT ins;
		wbT exp;
		logic [4:0] dst;
		ins.valid = 1'b1;
		ins.op = op;
		ins.rs = rs;
		ins.rt = rt;
		ins.rd = rd;
		ins.imm = imm;
		ins.pc = pc;
		dst = destReg(op, rt, rd);
		@(posedge clk);
		issue <= ins;
		if (op != NOP && dst != 5'd0) begin
			exp.valid = 1'b1;
			exp.addr = dst;
			exp.data = expectedResult(op, refRegs[rs], refRegs[rt], imm, pc);
			refRegs[dst] = exp.data;
			expQ.push_back(exp);
			expCyc.push_back(cyc + 6);	// Capture edge, 4 stages, then the monitor edge.
		end
	endtask

	task automatic loadReg(input logic [4:0] r, input logic [31:0] val);
		sendOp(LUI, 5'd0, r, 5'd0, val[31:16], 32'h0);
		sendOp(ORI, r, r, 5'd0, val[15:0], 32'h0);
	endtask

	task automatic drainWb();
		int i;
		@(posedge clk);
		issue <= '0;
		for (i = 0; i < 100 && expQ.size() != 0; i++)
			@(posedge clk);
		if (expQ.size() != 0) begin
			$display("Timed out with %0d writebacks still missing", expQ.size());
			errCount++;
			expQ.delete();
			expCyc.delete();
		end
		repeat (6) @(posedge clk);	// Catches stray writebacks.
	endtask

	task automatic reportTest(input string name, input int errStart);
		testsRun++;
		if (totalErrors() != errStart) begin
			testsFailed++;
			$display("%s: FAIL (%0d errors)", name, totalErrors() - errStart);
		end else begin
			$display("%s: pass", name);
		end
	endtask

	// ************************************************************
	// Directed tests
	// ************************************************************
	task automatic resetAndLoad();
		int errStart;
		errStart = totalErrors();
		@(posedge clk);
		checkData("wb.valid", 32'(wb.valid), 32'h0);
		loadReg(5'd1, 32'h1234_5678);
		loadReg(5'd2, 32'hdead_beef);
		loadReg(5'd3, 32'h0000_ffff);
		loadReg(5'd4, 32'h8000_0001);
		drainWb();
		reportTest("reset and load", errStart);
	endtask

	task automatic independentOps();
		int errStart;
		int r;
		errStart = totalErrors();
		for (r = 1; r <= 8; r++)
			loadReg(5'(r), $random(seed));
		sendOp(ADD, 5'd1, 5'd2, 5'd10, 16'h0, 32'h0);
		sendOp(SUB, 5'd3, 5'd4, 5'd11, 16'h0, 32'h0);
		sendOp(AND, 5'd5, 5'd6, 5'd12, 16'h0, 32'h0);
		sendOp(OR, 5'd7, 5'd8, 5'd13, 16'h0, 32'h0);
		sendOp(MUL, 5'd1, 5'd8, 5'd14, 16'h0, 32'h0);
		drainWb();
		reportTest("independent ops", errStart);
	endtask

	task automatic forwardDistances();
		int errStart;
		int d;
		errStart = totalErrors();
		for (d = 1; d <= 5; d++) begin
			sendOp(ADDI, 5'd1, 5'd15, 5'd0, 16'(d * 3), 32'h0);
			repeat (d - 1) sendOp(NOP, 5'd0, 5'd0, 5'd0, 16'h0, 32'h0);
			sendOp(ADD, 5'd15, 5'd15, 5'd16, 16'h0, 32'h0);	// Both sources forwarded.
			sendOp(SUB, 5'd2, 5'd16, 5'd17, 16'h0, 32'h0);
		end
		drainWb();
		reportTest("forwarding distances", errStart);
	endtask

	task automatic youngestWins();
		int errStart;
		errStart = totalErrors();
		sendOp(ADDI, 5'd1, 5'd20, 5'd0, 16'h0001, 32'h0);
		sendOp(ADDI, 5'd2, 5'd20, 5'd0, 16'h0002, 32'h0);
		sendOp(ADD, 5'd20, 5'd20, 5'd21, 16'h0, 32'h0);
		sendOp(MUL, 5'd3, 5'd4, 5'd22, 16'h0, 32'h0);
		sendOp(OR, 5'd5, 5'd6, 5'd22, 16'h0, 32'h0);
		sendOp(NOP, 5'd0, 5'd0, 5'd0, 16'h0, 32'h0);
		sendOp(AND, 5'd22, 5'd7, 5'd23, 16'h0, 32'h0);
		drainWb();
		reportTest("youngest producer", errStart);
	endtask

	task automatic linkAndZero();
		int errStart;
		logic [31:0] pc;
		errStart = totalErrors();
		pc = $random(seed);
		pc[1:0] = 2'b00;
		sendOp(JAL, 5'd0, 5'd0, 5'd0, 16'h0, pc);
		sendOp(ADD, 5'd1, 5'd2, 5'd0, 16'h0, 32'h0);	// No writeback expected.
		sendOp(NOP, 5'd1, 5'd2, 5'd3, 16'h0, 32'h0);
		sendOp(ADDI, 5'd1, 5'd0, 5'd0, 16'h0055, 32'h0);
		sendOp(OR, 5'd0, 5'd0, 5'd24, 16'h0, 32'h0);
		sendOp(ADD, 5'd0, 5'd31, 5'd25, 16'h0, 32'h0);
		drainWb();
		reportTest("link and r0", errStart);
	endtask

	task automatic randomStream();
		int errStart;
		int i;
		logic [31:0] rnd;
		logic [31:0] pc;
		opE op;
		errStart = totalErrors();
		for (i = 0; i < 20; i++) begin
			rnd = $random(seed);
			pc = $random(seed);
			op = opE'(4'(rnd[7:0] % 9) + 4'd1);
			sendOp(op, 5'(rnd[10:8]), 5'(rnd[13:11]), 5'(rnd[16:14]), rnd[31:16],
				{pc[31:2], 2'b00});
		end
		drainWb();
		reportTest("random stream", errStart);
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		issue = '0;
		cyc = '0;
		errCount = 0;
		testsRun = 0;
		testsFailed = 0;
		for (int r = 0; r < 32; r++)
			refRegs[r] = 32'h0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		resetAndLoad();
		independentOps();
		forwardDistances();
		youngestWins();
		linkAndZero();
		randomStream();
		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed,
			totalErrors());
		if (totalErrors() == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#200000;
		$display("Simulation ran past its time limit");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/dp_pkg.sv
hw/instrDecode.sv
hw/regFile.sv
hw/operandForward.sv
hw/execUnit.sv
hw/stageReg.sv
hw/writebackSelect.sv
hw/dpCore.sv
tb/dpCore_assert.sv
tb/dpCore_tb.sv

// ==== Bender.yml ====
package:
  name: dp_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dp_pkg.sv
      - hw/instrDecode.sv
      - hw/regFile.sv
      - hw/operandForward.sv
      - hw/execUnit.sv
      - hw/stageReg.sv
      - hw/writebackSelect.sv
      - hw/dpCore.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/dpCore_assert.sv
      - tb/dpCore_tb.sv
